// ==== filelist.f ====
exec_pkg.sv
exec_alu.sv
exec_branch_unit.sv
exec_result_stage.sv
exec_top.sv
exec_sva.sv
tb_exec_top.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - exec_pkg.sv
  - exec_alu.sv
  - exec_branch_unit.sv
  - exec_result_stage.sv
  - exec_top.sv
  - target: test
    files:
      - exec_sva.sv
      - tb_exec_top.sv

// ==== tb_exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exec_top;

localparam int unsigned XLEN       = 32;
localparam int          WAIT_LIMIT = 20;

logic                clk;
logic                rst;
logic                valid_i;
logic                stall_i;
logic                flush_i;
exec_pkg::alu_op_t   alu_op_i;
exec_pkg::br_op_t    br_op_i;
exec_pkg::ewb_sel_t  ewb_sel_i;
logic [XLEN-1:0]     pc_i;
logic [XLEN-1:0]     a_i;
logic [XLEN-1:0]     b_i;
logic [XLEN-1:0]     imm_i;
logic                valid_o;
logic [XLEN-1:0]     result_o;
logic                redirect_o;
logic [XLEN-1:0]     target_o;

integer seed;
int     mismatches;
int     timeouts;

exec_top #(
    .XLEN (XLEN)
) u_dut (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .alu_op_i   (alu_op_i),
    .br_op_i    (br_op_i),
    .ewb_sel_i  (ewb_sel_i),
    .pc_i       (pc_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .imm_i      (imm_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .redirect_o (redirect_o),
    .target_o   (target_o)
);

// 40 ns period
always #20 clk = ~clk;

// --------------------
// reference model
// --------------------
function automatic void predict(
    input  exec_pkg::alu_op_t  aop,
    input  exec_pkg::br_op_t   bop,
    input  exec_pkg::ewb_sel_t sel,
    input  logic [XLEN-1:0]    pc_v,
    input  logic [XLEN-1:0]    a_v,
    input  logic [XLEN-1:0]    b_v,
    input  logic [XLEN-1:0]    imm_v,
    output logic [XLEN-1:0]    res,
    output logic               tk,
    output logic [XLEN-1:0]    tgt
);
    int unsigned     sh;
    logic [XLEN-1:0] alu_v;
    sh = b_v % XLEN;
    case (aop)
        exec_pkg::ALU_ADD:  alu_v = a_v + b_v;
        exec_pkg::ALU_SUB:  alu_v = a_v - b_v;
        exec_pkg::ALU_SLL:  alu_v = a_v << sh;
        exec_pkg::ALU_SLT:  alu_v = XLEN'($signed(a_v) < $signed(b_v));
        exec_pkg::ALU_SLTU: alu_v = XLEN'(a_v < b_v);
        exec_pkg::ALU_XOR:  alu_v = a_v ^ b_v;
        exec_pkg::ALU_SRL:  alu_v = a_v >> sh;
        exec_pkg::ALU_SRA:  alu_v = $signed(a_v) >>> sh;
        exec_pkg::ALU_OR:   alu_v = a_v | b_v;
        exec_pkg::ALU_AND:  alu_v = a_v & b_v;
        default:            alu_v = '0;
    endcase
    case (bop)
        exec_pkg::BR_EQ:   tk = (a_v == b_v);
        exec_pkg::BR_NE:   tk = (a_v != b_v);
        exec_pkg::BR_LT:   tk = ($signed(a_v) < $signed(b_v));
        exec_pkg::BR_GE:   tk = ($signed(a_v) >= $signed(b_v));
        exec_pkg::BR_LTU:  tk = (a_v < b_v);
        exec_pkg::BR_GEU:  tk = (a_v >= b_v);
        exec_pkg::BR_JAL:  tk = 1'b1;
        exec_pkg::BR_JALR: tk = 1'b1;
        default:           tk = 1'b0;
    endcase
    case (bop)
        exec_pkg::BR_NONE: tgt = '0;
        exec_pkg::BR_JALR: tgt = (a_v + imm_v) & ~XLEN'(1);
        default:           tgt = pc_v + imm_v;
    endcase
    case (sel)
        exec_pkg::EWB_SEL_ALU:     res = alu_v;
        exec_pkg::EWB_SEL_IMM_U:   res = b_v;
        exec_pkg::EWB_SEL_PC_INC4: res = pc_v + XLEN'(4);
        default:                   res = '0;
    endcase
endfunction

// --------------------
// compare and wait helpers
// --------------------
task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (act !== exp) begin
        $display("MISMATCH %s expected=0x%h actual=0x%h", name, exp, act);
        mismatches++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("MISMATCH %s expected=0x%h actual=0x%h", name, exp, act);
        mismatches++;
    end
endtask

// one edge, then settle past it
task automatic step();
    @(posedge clk);
    #2;
endtask

task automatic wait_valid(output bit seen);
    int cycles;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
        if (valid_o === 1'b1) begin
            seen = 1'b1;
        end else begin
            step();
            cycles++;
        end
    end
    if (!seen) begin
        $display("timeout: valid_o did not rise after an accepted instruction");
        timeouts++;
    end
endtask

task automatic drive(input exec_pkg::alu_op_t aop, input exec_pkg::br_op_t bop,
                     input exec_pkg::ewb_sel_t sel, input logic [XLEN-1:0] pc_v,
                     input logic [XLEN-1:0] a_v, input logic [XLEN-1:0] b_v,
                     input logic [XLEN-1:0] imm_v);
    valid_i   = 1'b1;
    alu_op_i  = aop;
    br_op_i   = bop;
    ewb_sel_i = sel;
    pc_i      = pc_v;
    a_i       = a_v;
    b_i       = b_v;
    imm_i     = imm_v;
endtask

// issue one instruction and compare against the model
task automatic run_instr(input exec_pkg::alu_op_t aop, input exec_pkg::br_op_t bop,
                         input exec_pkg::ewb_sel_t sel, input logic [XLEN-1:0] pc_v,
                         input logic [XLEN-1:0] a_v, input logic [XLEN-1:0] b_v,
                         input logic [XLEN-1:0] imm_v);
    logic [XLEN-1:0] e_res;
    logic [XLEN-1:0] e_tgt;
    logic            e_tk;
    bit              seen;
    predict(aop, bop, sel, pc_v, a_v, b_v, imm_v, e_res, e_tk, e_tgt);
    drive(aop, bop, sel, pc_v, a_v, b_v, imm_v);
    step();
    valid_i = 1'b0;
    wait_valid(seen);
    if (seen) begin
        check_word("result_o", e_res, result_o);
        check_bit("redirect_o", e_tk, redirect_o);
        check_word("target_o", e_tgt, target_o);
    end
endtask

// --------------------
// directed tests
// --------------------
task automatic test_reset();
    // a live jump during reset must not escape
    drive(exec_pkg::ALU_ADD, exec_pkg::BR_JAL, exec_pkg::EWB_SEL_ALU, 32'h100, 1, 2, 8);
    repeat (10) begin
        step();
        check_bit("valid_o", 1'b0, valid_o);
        check_bit("redirect_o", 1'b0, redirect_o);
    end
    rst     = 1'b0;
    valid_i = 1'b0;
    step();
    check_bit("valid_o", 1'b0, valid_o);
    check_bit("redirect_o", 1'b0, redirect_o);
    check_word("result_o", '0, result_o);
    check_word("target_o", '0, target_o);
endtask

task automatic test_alu_ops();
    exec_pkg::alu_op_t op;
    op = op.first();
    repeat (op.num()) begin
        repeat (3) begin
            run_instr(op, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU, 0,
                      $random(seed), $random(seed), 0);
        end
        // shift amounts 0 and 31, then signed compare corners
        run_instr(op, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU, 0, $random(seed), 0, 0);
        run_instr(op, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU, 0, 32'h8000_00f1, 31, 0);
        run_instr(op, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU, 0,
                  32'h8000_0000, 32'h7fff_ffff, 0);
        run_instr(op, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU, 0,
                  32'h7fff_ffff, 32'h8000_0000, 0);
        run_instr(op, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU, 0, 32'hffff_ffff, 1, 0);
        op = op.next();
    end
endtask

task automatic test_wb_select();
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_IMM_U, 0,
              $random(seed), 32'h1234_5000, 0);
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_PC_INC4,
              $random(seed) & ~32'h3, $random(seed), $random(seed), 0);
    // pc+4 wraps to zero
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_PC_INC4,
              32'hffff_fffc, 0, 0, 0);
endtask

task automatic test_branches();
    exec_pkg::br_op_t op;
    op = exec_pkg::BR_EQ;
    while (op != exec_pkg::BR_JAL) begin
        run_instr(exec_pkg::ALU_ADD, op, exec_pkg::EWB_SEL_ALU, 32'h400,
                  32'h1234, 32'h1234, 32'h40);
        run_instr(exec_pkg::ALU_ADD, op, exec_pkg::EWB_SEL_ALU, 32'h800,
                  32'hffff_fff0, 32'h10, 32'hffff_fff8);
        run_instr(exec_pkg::ALU_ADD, op, exec_pkg::EWB_SEL_ALU, $random(seed) & ~32'h3,
                  32'h10, 32'h8000_0000, $random(seed) & ~32'h1);
        op = op.next();
    end
endtask

task automatic test_jumps();
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_JAL, exec_pkg::EWB_SEL_PC_INC4,
              32'h1000, 0, 0, 32'h800);
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_JAL, exec_pkg::EWB_SEL_PC_INC4,
              32'h2000, 0, 0, 32'hffff_f000);
    // odd sum, lsb must clear
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_JALR, exec_pkg::EWB_SEL_PC_INC4,
              32'h3000, 32'h2003, 0, 32'h10);
    run_instr(exec_pkg::ALU_ADD, exec_pkg::BR_JALR, exec_pkg::EWB_SEL_PC_INC4,
              32'h3100, 32'h5000, 0, 32'hffff_ffff);
endtask

task automatic test_stall_flush();
    logic [XLEN-1:0] held_res;
    logic [XLEN-1:0] held_tgt;
    bit              seen;
    int              i;
    drive(exec_pkg::ALU_ADD, exec_pkg::BR_EQ, exec_pkg::EWB_SEL_ALU, 32'h600, 7, 7, 32'h20);
    step();
    valid_i = 1'b0;
    wait_valid(seen);
    check_bit("redirect_o", 1'b1, redirect_o);
    held_res = result_o;
    held_tgt = target_o;
    stall_i  = 1'b1;
    for (i = 0; i < 3; i++) begin
        // not-taken filler, valid dropped in the middle cycle
        drive(exec_pkg::ALU_XOR, exec_pkg::BR_NONE, exec_pkg::EWB_SEL_ALU,
              $random(seed), $random(seed), $random(seed), $random(seed));
        valid_i = (i != 1);
        step();
        check_bit("valid_o", 1'b1, valid_o);
        check_bit("redirect_o", 1'b1, redirect_o);
        check_word("result_o", held_res, result_o);
        check_word("target_o", held_tgt, target_o);
    end
    stall_i = 1'b0;
    flush_i = 1'b1;
    drive(exec_pkg::ALU_ADD, exec_pkg::BR_JAL, exec_pkg::EWB_SEL_PC_INC4, 32'h700, 0, 0, 8);
    step();
    check_bit("valid_o", 1'b0, valid_o);
    check_bit("redirect_o", 1'b0, redirect_o);
    check_word("result_o", held_res, result_o);
    check_word("target_o", held_tgt, target_o);
    flush_i = 1'b0;
    valid_i = 1'b0;
    step();
    check_bit("valid_o", 1'b0, valid_o);
endtask

initial begin
    seed       = 98741;
    mismatches = 0;
    timeouts   = 0;
    clk        = 1'b0;
    rst        = 1'b1;
    valid_i    = 1'b0;
    stall_i    = 1'b0;
    flush_i    = 1'b0;
    alu_op_i   = exec_pkg::ALU_ADD;
    br_op_i    = exec_pkg::BR_NONE;
    ewb_sel_i  = exec_pkg::EWB_SEL_ALU;
    pc_i       = '0;
    a_i        = '0;
    b_i        = '0;
    imm_i      = '0;

    test_reset();
    test_alu_ops();
    test_wb_select();
    test_branches();
    test_jumps();
    test_stall_flush();

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== exec_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_sva #(
    parameter int unsigned XLEN = 32
) (
    input logic            clk,
    input logic            rst,
    input logic            stall_i,
    input logic            flush_i,
    input logic            valid_o,
    input logic            redirect_o,
    input logic [XLEN-1:0] result_o,
    input logic [XLEN-1:0] target_o
);

redirect_needs_valid: assert property (@(posedge clk) disable iff (rst)
    redirect_o |-> valid_o)
    else $error("redirect_o high while valid_o low");

flush_kills_valid: assert property (@(posedge clk) disable iff (rst)
    flush_i |=> !valid_o)
    else $error("valid_o high one cycle after flush_i");

// stalled register keeps every output
stall_holds_outputs: assert property (@(posedge clk) disable iff (rst)
    (stall_i && !flush_i) |=> ($stable(valid_o) && $stable(redirect_o)
                               && $stable(result_o) && $stable(target_o)))
    else $error("outputs changed across a stall");

reset_clears_valid: assert property (@(posedge clk) rst |=> !valid_o)
    else $error("valid_o high one cycle after rst");

endmodule

bind exec_top exec_sva #(
    .XLEN (XLEN)
) u_sva (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .valid_o    (valid_o),
    .redirect_o (redirect_o),
    .result_o   (result_o),
    .target_o   (target_o)
);

`default_nettype wire

// ==== exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_top #(
    parameter int unsigned XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  exec_pkg::alu_op_t   alu_op_i,
    input  exec_pkg::br_op_t    br_op_i,
    input  exec_pkg::ewb_sel_t  ewb_sel_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic [XLEN-1:0]     a_i,
    input  logic [XLEN-1:0]     b_i,
    input  logic [XLEN-1:0]     imm_i,
    output logic                valid_o,
    output logic [XLEN-1:0]     result_o,
    output logic                redirect_o,
    output logic [XLEN-1:0]     target_o
);

logic [XLEN-1:0] alu_result;
logic            taken;
logic [XLEN-1:0] target;

// --------------------
// execute datapath
// --------------------
exec_alu #(
    .XLEN (XLEN)
) u_alu (
    .a_i      (a_i),
    .b_i      (b_i),
    .op_i     (alu_op_i),
    .result_o (alu_result)
);

// runs beside the ALU on the same operands
exec_branch_unit #(
    .XLEN (XLEN)
) u_branch (
    .a_i      (a_i),
    .b_i      (b_i),
    .pc_i     (pc_i),
    .imm_i    (imm_i),
    .op_i     (br_op_i),
    .taken_o  (taken),
    .target_o (target)
);

// --------------------
// EXE/MEM boundary
// --------------------
exec_result_stage #(
    .XLEN (XLEN)
) u_result (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (valid_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .ewb_sel_i    (ewb_sel_i),
    .alu_result_i (alu_result),
    .b_i          (b_i),
    .pc_i         (pc_i),
    .target_i     (target),
    .taken_i      (taken),
    .valid_o      (valid_o),
    .redirect_o   (redirect_o),
    .result_o     (result_o),
    .target_o     (target_o)
);

endmodule

`default_nettype wire

// ==== exec_result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_result_stage #(
    parameter int unsigned XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  exec_pkg::ewb_sel_t  ewb_sel_i,
    input  logic [XLEN-1:0]     alu_result_i,
    input  logic [XLEN-1:0]     b_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic [XLEN-1:0]     target_i,
    input  logic                taken_i,
    output logic                valid_o,
    output logic                redirect_o,
    output logic [XLEN-1:0]     result_o,
    output logic [XLEN-1:0]     target_o
);

// --------------------
// writeback select
// --------------------
logic [XLEN-1:0] pc_inc4;
logic [XLEN-1:0] wb_value;

// link value for jal and jalr
assign pc_inc4 = pc_i + XLEN'(4);

always_comb begin
    case (ewb_sel_i)
        exec_pkg::EWB_SEL_ALU:     wb_value = alu_result_i;
        // lui style immediate arrives on operand b
        exec_pkg::EWB_SEL_IMM_U:   wb_value = b_i;
        exec_pkg::EWB_SEL_PC_INC4: wb_value = pc_inc4;
        default:                   wb_value = '0;
    endcase
end

// --------------------
// EXE/MEM register
// --------------------
logic            valid_q;
logic            taken_q;
logic [XLEN-1:0] result_q;
logic [XLEN-1:0] target_q;
logic            accept;

// new instruction enters only when the memory stage moves
assign accept = valid_i && !stall_i;

always_ff @(posedge clk) begin
    if (rst) begin
        valid_q  <= 1'b0;
        taken_q  <= 1'b0;
        result_q <= '0;
        target_q <= '0;
    end else if (flush_i) begin
        // squash wins over stall, payload keeps its old value
        valid_q <= 1'b0;
        taken_q <= 1'b0;
    end else if (!stall_i) begin
        valid_q <= valid_i;
        taken_q <= taken_i;
        if (accept) begin
            result_q <= wb_value;
            target_q <= target_i;
        end
    end
end

// --------------------
// outputs
// --------------------
assign valid_o    = valid_q;
// taken alone is not enough, only a live instruction redirects
assign redirect_o = valid_q && taken_q;
assign result_o   = result_q;
assign target_o   = target_q;

endmodule

`default_nettype wire

// ==== exec_branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_branch_unit #(
    parameter int unsigned XLEN = 32
) (
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic [XLEN-1:0]  imm_i,
    input  exec_pkg::br_op_t op_i,
    output logic             taken_o,
    output logic [XLEN-1:0]  target_o
);

// --------------------
// branch compare
// --------------------
logic a_eq_b;
logic a_lt_b_s;
logic a_lt_b_u;

assign a_eq_b   = (a_i == b_i);
assign a_lt_b_s = ($signed(a_i) < $signed(b_i));
assign a_lt_b_u = (a_i < b_i);

// resolution by branch kind
always_comb begin
    case (op_i)
        exec_pkg::BR_EQ:   taken_o = a_eq_b;
        exec_pkg::BR_NE:   taken_o = !a_eq_b;
        exec_pkg::BR_LT:   taken_o = a_lt_b_s;
        exec_pkg::BR_GE:   taken_o = !a_lt_b_s;
        exec_pkg::BR_LTU:  taken_o = a_lt_b_u;
        exec_pkg::BR_GEU:  taken_o = !a_lt_b_u;
        exec_pkg::BR_JAL:  taken_o = 1'b1;
        exec_pkg::BR_JALR: taken_o = 1'b1;
        default:           taken_o = 1'b0;
    endcase
end

// --------------------
// target adder
// --------------------
logic            is_jalr;
logic [XLEN-1:0] tgt_base;
logic [XLEN-1:0] tgt_sum;

assign is_jalr  = (op_i == exec_pkg::BR_JALR);

// jalr is register relative, the rest pc relative
assign tgt_base = is_jalr ? a_i : pc_i;
assign tgt_sum  = tgt_base + imm_i;

always_comb begin
    case (op_i)
        exec_pkg::BR_EQ,
        exec_pkg::BR_NE,
        exec_pkg::BR_LT,
        exec_pkg::BR_GE,
        exec_pkg::BR_LTU,
        exec_pkg::BR_GEU,
        exec_pkg::BR_JAL:  target_o = tgt_sum;
        // lsb forced low for jalr only
        exec_pkg::BR_JALR: target_o = {tgt_sum[XLEN-1:1], 1'b0};
        // br_none and unused codes
        default:           target_o = '0;
    endcase
end

endmodule

`default_nettype wire

// ==== exec_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_alu #(
    parameter int unsigned XLEN = 32
) (
    input  logic [XLEN-1:0]   a_i,
    input  logic [XLEN-1:0]   b_i,
    input  exec_pkg::alu_op_t op_i,
    output logic [XLEN-1:0]   result_o
);

// --------------------
// shared subtractor
// --------------------
// extra top bit holds the unsigned borrow
logic [XLEN:0]   sub_ext;
logic [XLEN-1:0] diff;
logic            lt_u;
logic            lt_s;

assign sub_ext = {1'b0, a_i} - {1'b0, b_i};
assign diff    = sub_ext[XLEN-1:0];
assign lt_u    = sub_ext[XLEN];

// signs differ: the negative one is smaller, else no overflow in diff
assign lt_s = (a_i[XLEN-1] != b_i[XLEN-1]) ? a_i[XLEN-1] : diff[XLEN-1];

// --------------------
// adder and shifter
// --------------------
logic [XLEN-1:0]              sum;
logic [exec_pkg::SHAMT_W-1:0] shamt;
logic [XLEN-1:0]              sll_res;
logic [XLEN-1:0]              srl_res;
logic [XLEN-1:0]              sra_res;

assign sum   = a_i + b_i;

// only the low bits of b count for shifts
assign shamt = b_i[exec_pkg::SHAMT_W-1:0];

assign sll_res = a_i << shamt;
assign srl_res = a_i >> shamt;
assign sra_res = $signed(a_i) >>> shamt;

// --------------------
// result mux
// --------------------
always_comb begin
    case (op_i)
        exec_pkg::ALU_ADD:  result_o = sum;
        exec_pkg::ALU_SUB:  result_o = diff;
        exec_pkg::ALU_SLL:  result_o = sll_res;
        exec_pkg::ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
        exec_pkg::ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
        exec_pkg::ALU_XOR:  result_o = a_i ^ b_i;
        exec_pkg::ALU_SRL:  result_o = srl_res;
        exec_pkg::ALU_SRA:  result_o = sra_res;
        exec_pkg::ALU_OR:   result_o = a_i | b_i;
        exec_pkg::ALU_AND:  result_o = a_i & b_i;
        // unused encodings
        default:            result_o = '0;
    endcase
end

endmodule

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // --------------------
    // widths
    // --------------------
    // shift amount for XLEN of 32, a 64 bit datapath needs 6
    localparam int unsigned SHAMT_W = 5;

    // --------------------
    // integer ALU operations
    // --------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // --------------------
    // control flow kinds
    // --------------------
    // six conditional branches, then the two unconditional jumps
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } br_op_t;

    // --------------------
    // execute writeback source
    // --------------------
    // imm_u comes in on operand b, pc_inc4 is the link value of a jump
    typedef enum logic [1:0] {
        EWB_SEL_ALU     = 2'd0,
        EWB_SEL_IMM_U   = 2'd1,
        EWB_SEL_PC_INC4 = 2'd2
    } ewb_sel_t;

endpackage

`default_nettype wire
